//--- source/htfu_pkg.sv
`default_nettype none

package htfu_pkg;

    // Keys and values
    typedef logic [7:0]  key_t;
    typedef logic [15:0] value_t;

    typedef struct packed {
        key_t   key;
        logic   insert;
        value_t value;
    } stash_entry_t;

    // Update stash
    localparam int STASH_DEPTH = 8;
    localparam int STASH_PTR_W = $clog2(STASH_DEPTH);
    typedef logic [3:0] fill_t;

    // Table geometry, low key bits index and high key bits form the tag
    localparam int TBL_IDX_W = 4;
    localparam int TBL_TAG_W = $bits(key_t) - TBL_IDX_W;
    localparam int TBL_SLOTS = 1 << TBL_IDX_W;

    // Lookup timing and make-before-break hold
    localparam int LOOKUP_LATENCY = 2;
    localparam int POP_WAIT       = LOOKUP_LATENCY;
    localparam int HOLD_CNT_W     = $clog2(POP_WAIT + 1);

    // Register block
    typedef logic [31:0] cnt_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam int CNT_NUM = 5;

    localparam apb_addr_t REG_CONTROL      = 8'h00;
    localparam apb_addr_t REG_STATUS       = 8'h04;
    localparam apb_addr_t REG_CNT_UPDATE   = 8'h08;
    localparam apb_addr_t REG_CNT_INS_OK   = 8'h0C;
    localparam apb_addr_t REG_CNT_INS_FAIL = 8'h10;
    localparam apb_addr_t REG_CNT_DEL_OK   = 8'h14;
    localparam apb_addr_t REG_CNT_DEL_FAIL = 8'h18;

endpackage

`default_nettype wire

//--- source/htfu_regs.sv
`default_nettype none

module htfu_regs (
    input  logic                clk,
    input  logic                __srst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  htfu_pkg::apb_addr_t paddr,
    input  htfu_pkg::apb_data_t pwdata,
    output htfu_pkg::apb_data_t prdata,
    output logic                pslverr,
    input  htfu_pkg::fill_t     fill,
    input  logic                ev_update,
    input  logic                ins_ok,
    input  logic                ins_fail,
    input  logic                del_ok,
    input  logic                del_fail,
    output logic                enable
);

    logic                      access;
    logic                      ctrl_wr;
    logic                      cnt_clear;
    logic                      mapped;
    logic [htfu_pkg::CNT_NUM-1:0] events;
    htfu_pkg::cnt_t            cnt [htfu_pkg::CNT_NUM];

    // --------------------
    // Access decode
    // --------------------
    // Zero wait states, so the access phase is the whole transfer
    assign access    = psel && penable;
    assign ctrl_wr   = access && pwrite && (paddr == htfu_pkg::REG_CONTROL);
    assign cnt_clear = ctrl_wr && pwdata[1];

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            htfu_pkg::REG_CONTROL:      prdata = htfu_pkg::apb_data_t'(enable);
            htfu_pkg::REG_STATUS:       prdata = htfu_pkg::apb_data_t'(fill);
            htfu_pkg::REG_CNT_UPDATE:   prdata = cnt[0];
            htfu_pkg::REG_CNT_INS_OK:   prdata = cnt[1];
            htfu_pkg::REG_CNT_INS_FAIL: prdata = cnt[2];
            htfu_pkg::REG_CNT_DEL_OK:   prdata = cnt[3];
            htfu_pkg::REG_CNT_DEL_FAIL: prdata = cnt[4];
            default:                    mapped = 1'b0;
        endcase
    end

    // Only the control register takes writes
    assign pslverr = access && (!mapped || (pwrite && paddr != htfu_pkg::REG_CONTROL));

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            enable <= 1'b0;
        end else if (ctrl_wr) begin
            enable <= pwdata[0];
        end
    end

    // --------------------
    // Event counters
    // --------------------
    // Same order as the counter registers
    assign events = {del_fail, del_ok, ins_fail, ins_ok, ev_update};

    always_ff @(posedge clk) begin
        for (int i = 0; i < htfu_pkg::CNT_NUM; i++) begin
            if (__srst || cnt_clear) begin
                cnt[i] <= '0;
            end else if (events[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    // Requester must open every transfer with a setup phase
    assert property (@(posedge clk) disable iff (__srst)
        penable |-> psel);

endmodule

`default_nettype wire

//--- source/htfu_stash.sv
`default_nettype none

module htfu_stash (
    input  logic                   clk,
    input  logic                   __srst,
    input  logic                   update_req,
    input  htfu_pkg::key_t         update_key,
    input  htfu_pkg::value_t       update_value,
    input  logic                   update_insert,
    output logic                   update_rdy,
    output logic                   ev_update,
    input  htfu_pkg::key_t         search_key,
    output logic                   search_hit,
    output htfu_pkg::stash_entry_t search_entry,
    output htfu_pkg::stash_entry_t head_entry,
    output htfu_pkg::fill_t        fill,
    input  logic                   pop
);

    htfu_pkg::stash_entry_t             mem [htfu_pkg::STASH_DEPTH];
    htfu_pkg::stash_entry_t             new_entry;
    logic [htfu_pkg::STASH_PTR_W-1:0]   wr_ptr;
    logic [htfu_pkg::STASH_PTR_W-1:0]   rd_ptr;
    logic                               accept;

    // --------------------
    // Accept side
    // --------------------
    assign update_rdy = (fill < htfu_pkg::fill_t'(htfu_pkg::STASH_DEPTH));
    assign accept     = update_req && update_rdy;
    assign ev_update  = accept;

    assign new_entry.key    = update_key;
    assign new_entry.insert = update_insert;
    assign new_entry.value  = update_value;

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr] <= new_entry;
        end
    end

    // Pointers and fill
    always_ff @(posedge clk) begin
        if (__srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({accept, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // --------------------
    // Search
    // --------------------
    // Walk from oldest to newest so the newest match is kept
    always_comb begin
        logic [htfu_pkg::STASH_PTR_W-1:0] idx;
        search_hit   = 1'b0;
        search_entry = '0;
        for (int i = 0; i < htfu_pkg::STASH_DEPTH; i++) begin
            idx = rd_ptr + htfu_pkg::STASH_PTR_W'(i);
            if ((i < int'(fill)) && (mem[idx].key == search_key)) begin
                search_hit   = 1'b1;
                search_entry = mem[idx];
            end
        end
    end

    // Oldest pending entry for the drain
    assign head_entry = mem[rd_ptr];

    // Drain must never pop an empty stash
    assert property (@(posedge clk) disable iff (__srst)
        pop |-> (fill != '0));

endmodule

`default_nettype wire

//--- source/htfu_drain_ctrl.sv
`default_nettype none

module htfu_drain_ctrl (
    input  logic                   clk,
    input  logic                   __srst,
    input  logic                   enable,
    input  htfu_pkg::fill_t        fill,
    input  htfu_pkg::stash_entry_t head_entry,
    output logic                   pop,
    output logic                   tbl_wr,
    output htfu_pkg::key_t         tbl_key,
    output logic                   tbl_insert,
    output htfu_pkg::value_t       tbl_value,
    input  logic                   tbl_ok,
    output logic                   ins_ok,
    output logic                   ins_fail,
    output logic                   del_ok,
    output logic                   del_fail
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WRITE = 2'd1,
        HOLD  = 2'd2,
        POP   = 2'd3
    } state_t;

    state_t                          state;
    state_t                          nxt_state;
    logic [htfu_pkg::HOLD_CNT_W-1:0] hold_cnt;
    logic                            hold_done;

    // Head entry stays put until popped, so drive the table from it
    assign tbl_key    = head_entry.key;
    assign tbl_insert = head_entry.insert;
    assign tbl_value  = head_entry.value;

    assign hold_done = (hold_cnt == htfu_pkg::HOLD_CNT_W'(htfu_pkg::POP_WAIT - 1));

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            state <= IDLE;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            IDLE: begin
                if (enable && fill != '0) begin
                    nxt_state = WRITE;
                end
            end
            // Failure skips the hold, nothing changed in the table
            WRITE: nxt_state = tbl_ok ? HOLD : POP;
            // Keep the entry visible while older lookups finish
            HOLD: begin
                if (hold_done) begin
                    nxt_state = POP;
                end
            end
            POP:     nxt_state = IDLE;
            default: nxt_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (__srst || state != HOLD) begin
            hold_cnt <= '0;
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // --------------------
    // Outputs
    // --------------------
    assign tbl_wr = (state == WRITE);
    assign pop    = (state == POP);

    // One event per entry, decided in the write cycle
    assign ins_ok   = tbl_wr &&  tbl_insert &&  tbl_ok;
    assign ins_fail = tbl_wr &&  tbl_insert && !tbl_ok;
    assign del_ok   = tbl_wr && !tbl_insert &&  tbl_ok;
    assign del_fail = tbl_wr && !tbl_insert && !tbl_ok;

    assert property (@(posedge clk) disable iff (__srst)
        !(tbl_wr && pop));

    // Make before break, pop lands only after in-flight lookups settle
    assert property (@(posedge clk) disable iff (__srst)
        (tbl_wr && tbl_ok) |-> ##(htfu_pkg::POP_WAIT + 1) pop);

endmodule

`default_nettype wire

//--- source/htfu_table.sv
`default_nettype none

module htfu_table (
    input  logic             clk,
    input  logic             __srst,
    input  htfu_pkg::key_t   rd_key,
    output logic             rd_valid,
    output htfu_pkg::value_t rd_value,
    input  logic             tbl_wr,
    input  htfu_pkg::key_t   tbl_key,
    input  logic             tbl_insert,
    input  htfu_pkg::value_t tbl_value,
    output logic             tbl_ok
);

    logic [htfu_pkg::TBL_SLOTS-1:0] slot_valid;
    logic [htfu_pkg::TBL_TAG_W-1:0] slot_tag   [htfu_pkg::TBL_SLOTS];
    htfu_pkg::value_t               slot_value [htfu_pkg::TBL_SLOTS];

    logic [htfu_pkg::TBL_IDX_W-1:0] wr_idx;
    logic [htfu_pkg::TBL_TAG_W-1:0] wr_tag;
    logic [htfu_pkg::TBL_IDX_W-1:0] rd_idx;
    logic [htfu_pkg::TBL_TAG_W-1:0] rd_tag;
    logic                           wr_match;

    assign {wr_tag, wr_idx} = tbl_key;
    assign {rd_tag, rd_idx} = rd_key;

    // Set/unset rules
    assign wr_match = slot_valid[wr_idx] && (slot_tag[wr_idx] == wr_tag);
    assign tbl_ok   = tbl_insert ? (!slot_valid[wr_idx] || wr_match) : wr_match;

    always_ff @(posedge clk) begin
        if (__srst) begin
            slot_valid <= '0;
        end else if (tbl_wr && tbl_ok) begin
            slot_valid[wr_idx] <= tbl_insert;
        end
    end

    always_ff @(posedge clk) begin
        if (tbl_wr && tbl_ok && tbl_insert) begin
            slot_tag[wr_idx]   <= wr_tag;
            slot_value[wr_idx] <= tbl_value;
        end
    end

    // Registered lookup, sees the contents before a same-cycle write
    always_ff @(posedge clk) begin
        if (__srst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= slot_valid[rd_idx] && (slot_tag[rd_idx] == rd_tag);
        end
        rd_value <= slot_value[rd_idx];
    end

endmodule

`default_nettype wire

//--- source/htfu_lookup_result.sv
`default_nettype none

module htfu_lookup_result (
    input  logic                   clk,
    input  logic                   __srst,
    input  logic                   lookup_req,
    input  logic                   search_hit,
    input  htfu_pkg::stash_entry_t search_entry,
    input  logic                   rd_valid,
    input  htfu_pkg::value_t       rd_value,
    output logic                   lookup_ack,
    output logic                   lookup_valid,
    output htfu_pkg::value_t       lookup_value
);

    logic                   req_q;
    logic                   hit_q;
    htfu_pkg::stash_entry_t entry_q;

    // Stage 1, stash result waits for the table read
    always_ff @(posedge clk) begin
        if (__srst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= lookup_req;
        end
        hit_q   <= search_hit;
        entry_q <= search_entry;
    end

    // Stage 2, a stash hit overrides the table
    always_ff @(posedge clk) begin
        if (__srst) begin
            lookup_ack   <= 1'b0;
            lookup_valid <= 1'b0;
        end else begin
            lookup_ack   <= req_q;
            lookup_valid <= hit_q ? entry_q.insert : rd_valid;
        end
        if (hit_q) begin
            lookup_value <= entry_q.insert ? entry_q.value : '0;
        end else begin
            lookup_value <= rd_valid ? rd_value : '0;
        end
    end

endmodule

`default_nettype wire

//--- source/htfu_top.sv
`default_nettype none

module htfu_top (
    input  logic                clk,
    input  logic                __srst,
    // APB
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  htfu_pkg::apb_addr_t paddr,
    input  htfu_pkg::apb_data_t pwdata,
    output htfu_pkg::apb_data_t prdata,
    output logic                pslverr,
    // Updates
    input  logic                update_req,
    input  htfu_pkg::key_t      update_key,
    input  htfu_pkg::value_t    update_value,
    input  logic                update_insert,
    output logic                update_rdy,
    // Lookups
    input  logic                lookup_req,
    input  htfu_pkg::key_t      lookup_key,
    output logic                lookup_ack,
    output logic                lookup_valid,
    output htfu_pkg::value_t    lookup_value
);

    logic                   enable;
    logic                   ev_update;
    logic                   ins_ok;
    logic                   ins_fail;
    logic                   del_ok;
    logic                   del_fail;
    htfu_pkg::fill_t        fill;
    logic                   search_hit;
    htfu_pkg::stash_entry_t search_entry;
    htfu_pkg::stash_entry_t head_entry;
    logic                   pop;
    logic                   tbl_wr;
    htfu_pkg::key_t         tbl_key;
    logic                   tbl_insert;
    htfu_pkg::value_t       tbl_value;
    logic                   tbl_ok;
    logic                   rd_valid;
    htfu_pkg::value_t       rd_value;

    htfu_regs i_regs (
        .clk, .__srst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pslverr,
        .fill, .ev_update, .ins_ok, .ins_fail, .del_ok, .del_fail, .enable
    );

    // Stash and table are searched with the same key in the same cycle
    htfu_stash i_stash (
        .clk, .__srst, .update_req, .update_key, .update_value, .update_insert,
        .update_rdy, .ev_update, .search_key(lookup_key), .search_hit, .search_entry,
        .head_entry, .fill, .pop
    );

    htfu_drain_ctrl i_drain_ctrl (
        .clk, .__srst, .enable, .fill, .head_entry, .pop, .tbl_wr, .tbl_key,
        .tbl_insert, .tbl_value, .tbl_ok, .ins_ok, .ins_fail, .del_ok, .del_fail
    );

    htfu_table i_table (
        .clk, .__srst, .rd_key(lookup_key), .rd_valid, .rd_value,
        .tbl_wr, .tbl_key, .tbl_insert, .tbl_value, .tbl_ok
    );

    htfu_lookup_result i_lookup_result (
        .clk, .__srst, .lookup_req, .search_hit, .search_entry, .rd_valid, .rd_value,
        .lookup_ack, .lookup_valid, .lookup_value
    );

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    // Period of 10, first rising edge at 5
    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

//--- sim/htfu_tb.sv
`default_nettype none

module htfu_tb;

    typedef struct packed {
        logic             valid;
        htfu_pkg::value_t value;
        logic [31:0]      due;
    } exp_lookup_t;

    logic                clk;
    logic                __srst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    htfu_pkg::apb_addr_t paddr;
    htfu_pkg::apb_data_t pwdata;
    htfu_pkg::apb_data_t prdata;
    logic                pslverr;
    logic                update_req;
    htfu_pkg::key_t      update_key;
    htfu_pkg::value_t    update_value;
    logic                update_insert;
    logic                update_rdy;
    logic                lookup_req;
    htfu_pkg::key_t      lookup_key;
    logic                lookup_ack;
    logic                lookup_valid;
    htfu_pkg::value_t    lookup_value;

    // Reference model, pending updates and a 16-slot table
    htfu_pkg::stash_entry_t ref_stash [$];
    logic                   ref_valid [htfu_pkg::TBL_SLOTS];
    logic [3:0]             ref_tag   [htfu_pkg::TBL_SLOTS];
    htfu_pkg::value_t       ref_value [htfu_pkg::TBL_SLOTS];
    htfu_pkg::cnt_t         ref_cnt   [htfu_pkg::CNT_NUM];

    exp_lookup_t exp_q [$];
    logic [31:0] cycle = '0;
    logic [31:0] lcg_state;
    int          timeout = 500;

    tb_clk_gen u_clk_gen (.clk);

    htfu_top u_dut (
        .clk, .__srst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pslverr,
        .update_req, .update_key, .update_value, .update_insert, .update_rdy,
        .lookup_req, .lookup_key, .lookup_ack, .lookup_valid, .lookup_value
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    // Newest pending update decides, otherwise the table slot
    function automatic logic ref_lookup(input htfu_pkg::key_t key,
                                        output htfu_pkg::value_t value);
        logic [3:0] idx;
        logic [3:0] tag;
        {tag, idx} = key;
        for (int i = ref_stash.size() - 1; i >= 0; i--) begin
            if (ref_stash[i].key == key) begin
                value = ref_stash[i].insert ? ref_stash[i].value : '0;
                return ref_stash[i].insert;
            end
        end
        value = (ref_valid[idx] && ref_tag[idx] == tag) ? ref_value[idx] : '0;
        return ref_valid[idx] && ref_tag[idx] == tag;
    endfunction

    // Insert needs a free or same-tag slot, delete needs a same-tag slot
    function automatic logic ref_apply(input htfu_pkg::stash_entry_t e);
        logic [3:0] idx;
        logic [3:0] tag;
        logic       same;
        logic       ok;
        {tag, idx} = e.key;
        same = ref_valid[idx] && ref_tag[idx] == tag;
        ok = e.insert ? (!ref_valid[idx] || same) : same;
        if (ok) begin
            ref_valid[idx] = e.insert;
            ref_tag[idx]   = tag;
            ref_value[idx] = e.value;
        end
        return ok;
    endfunction

    function automatic void ref_drain_all();
        htfu_pkg::stash_entry_t e;
        int                     slot;
        while (ref_stash.size() > 0) begin
            e = ref_stash.pop_front();
            // Counters 1 to 4 are ins ok, ins fail, del ok, del fail
            slot = ref_apply(e) ? (e.insert ? 1 : 3) : (e.insert ? 2 : 4);
            ref_cnt[slot] = ref_cnt[slot] + 1;
        end
    endfunction

    // --------------------
    // Checks
    // --------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_lookup(input logic got_valid, input htfu_pkg::value_t got_value,
                                input logic exp_valid, input htfu_pkg::value_t exp_value);
        if (got_valid !== exp_valid || got_value !== exp_value) begin
            report_failure($sformatf("** Error: lookup_valid/lookup_value = 0x%0h/0x%04h, %s",
                got_valid, got_value, $sformatf("expected 0x%0h/0x%04h", exp_valid, exp_value)));
        end
    endtask

    task automatic check_reg(input string name, input htfu_pkg::apb_data_t got,
                             input htfu_pkg::apb_data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_fill(input htfu_pkg::fill_t got, input htfu_pkg::fill_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: fill = 0x%0h, expected 0x%0h", got, exp));
        end
    endtask

    // Each lookup_ack is checked against the oldest expected result
    always @(negedge clk) begin : compare_lookups
        exp_lookup_t e;
        if (lookup_ack) begin
            if (exp_q.size() == 0) begin
                report_failure("lookup_ack came without a pending lookup");
            end else begin
                e = exp_q.pop_front();
                if (e.due != cycle) begin
                    report_failure("lookup_ack came at the wrong latency");
                end
                check_lookup(lookup_valid, lookup_value, e.valid, e.value);
            end
        end else if (exp_q.size() > 0 && exp_q[0].due <= cycle) begin
            report_failure("lookup_ack missing after a lookup request");
        end
    end

    // --------------------
    // Bus and port drivers
    // --------------------
    task automatic apb_access(input logic write, input htfu_pkg::apb_addr_t addr,
                              input htfu_pkg::apb_data_t wdata,
                              output htfu_pkg::apb_data_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_expect(input htfu_pkg::apb_addr_t addr, input htfu_pkg::apb_data_t exp);
        htfu_pkg::apb_data_t rdata;
        logic                err;
        apb_access(1'b0, addr, '0, rdata, err);
        if (err) begin
            report_failure($sformatf("read of offset 0x%02h returned pslverr", addr));
        end
        check_reg($sformatf("prdata[0x%02h]", addr), rdata, exp);
    endtask

    task automatic write_control(input htfu_pkg::apb_data_t data);
        htfu_pkg::apb_data_t rdata;
        logic                err;
        apb_access(1'b1, htfu_pkg::REG_CONTROL, data, rdata, err);
        if (err) begin
            report_failure("write to REG_CONTROL returned pslverr");
        end
    endtask

    task automatic check_counters();
        read_expect(htfu_pkg::REG_CNT_UPDATE, ref_cnt[0]);
        read_expect(htfu_pkg::REG_CNT_INS_OK, ref_cnt[1]);
        read_expect(htfu_pkg::REG_CNT_INS_FAIL, ref_cnt[2]);
        read_expect(htfu_pkg::REG_CNT_DEL_OK, ref_cnt[3]);
        read_expect(htfu_pkg::REG_CNT_DEL_FAIL, ref_cnt[4]);
    endtask

    // Update request is already driven, wait for the stash to take it
    task automatic wait_accept();
        int waited;
        waited = 0;
        while (!update_rdy) begin
            if (waited == timeout) begin
                report_failure("timeout waiting for update_rdy");
            end
            waited++;
            @(negedge clk);
        end
        ref_stash.push_back({update_key, update_insert, update_value});
        ref_cnt[0] = ref_cnt[0] + 1;
        @(negedge clk);
        update_req = 1'b0;
    endtask

    task automatic send_update(input htfu_pkg::key_t key, input htfu_pkg::value_t value,
                               input logic insert);
        update_req    = 1'b1;
        update_key    = key;
        update_value  = value;
        update_insert = insert;
        wait_accept();
    endtask

    task automatic issue_lookup(input htfu_pkg::key_t key);
        exp_lookup_t      e;
        htfu_pkg::value_t value;
        lookup_req = 1'b1;
        lookup_key = key;
        e.valid = ref_lookup(key, value);
        e.value = value;
        e.due   = cycle + htfu_pkg::LOOKUP_LATENCY;
        exp_q.push_back(e);
        @(negedge clk);
    endtask

    task automatic finish_lookups();
        int waited;
        waited = 0;
        lookup_req = 1'b0;
        while (exp_q.size() > 0) begin
            if (waited == timeout) begin
                report_failure("timeout waiting for lookup results");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic wait_drained();
        htfu_pkg::apb_data_t rdata;
        logic                err;
        int                  polls;
        polls = 0;
        apb_access(1'b0, htfu_pkg::REG_STATUS, '0, rdata, err);
        while (rdata[3:0] != '0) begin
            if (polls == timeout) begin
                report_failure("timeout waiting for the stash to drain");
            end
            polls++;
            apb_access(1'b0, htfu_pkg::REG_STATUS, '0, rdata, err);
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        htfu_pkg::apb_data_t rdata;
        logic                err;
        logic [31:0]         rnd;
        htfu_pkg::key_t      key;
        htfu_pkg::key_t      batch_key [6];
        __srst        = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        update_req    = 1'b0;
        update_key    = '0;
        update_value  = '0;
        update_insert = 1'b0;
        lookup_req    = 1'b0;
        lookup_key    = '0;
        lcg_state     = 32'hdaaf;
        for (int i = 0; i < htfu_pkg::TBL_SLOTS; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
            ref_value[i] = '0;
        end
        for (int i = 0; i < htfu_pkg::CNT_NUM; i++) begin
            ref_cnt[i] = '0;
        end
        repeat (5) @(negedge clk);
        __srst = 1'b0;

        // Reset state
        for (int a = 0; a <= 24; a += 4) begin
            read_expect(htfu_pkg::apb_addr_t'(a), '0);
        end
        if (!update_rdy) begin
            report_failure("update_rdy is low after reset");
        end
        rnd = lcg_next();
        issue_lookup(rnd[31:24]);
        finish_lookups();

        // Drain disabled, the stash answers on its own
        send_update(8'h12, 16'h1111, 1'b1);
        send_update(8'h34, 16'h2222, 1'b1);
        send_update(8'h12, 16'h3333, 1'b1);
        send_update(8'h56, 16'h4444, 1'b1);
        send_update(8'h56, 16'h0000, 1'b0);
        send_update(8'h22, 16'h5555, 1'b1);
        send_update(8'h7a, 16'h0000, 1'b0);
        rnd = lcg_next();
        send_update(rnd[31:24], rnd[23:8], 1'b1);
        issue_lookup(8'h12);
        issue_lookup(8'h34);
        issue_lookup(8'h56);
        issue_lookup(8'h22);
        issue_lookup(8'h7a);
        issue_lookup(8'h99);
        finish_lookups();
        if (update_rdy) begin
            report_failure("update_rdy stayed high with eight pending updates");
        end

        // A ninth update waits while the stash is full
        update_req    = 1'b1;
        update_key    = 8'h9c;
        update_value  = 16'h6666;
        update_insert = 1'b1;
        apb_access(1'b0, htfu_pkg::REG_STATUS, '0, rdata, err);
        check_fill(rdata[3:0], htfu_pkg::fill_t'(htfu_pkg::STASH_DEPTH));
        read_expect(htfu_pkg::REG_CNT_UPDATE, 32'd8);
        write_control(32'h1);
        wait_accept();

        // Drain enabled, few slots so inserts collide and deletes miss
        for (int i = 0; i < 24; i++) begin
            rnd = lcg_next();
            send_update({2'b00, rnd[29:28], 2'b00, rnd[27:26]}, rnd[23:8], rnd[25] | rnd[24]);
        end
        wait_drained();
        ref_drain_all();
        for (int i = 0; i < 16; i++) begin
            issue_lookup({2'b00, i[3:2], 2'b00, i[1:0]});
        end
        issue_lookup(8'h12);
        issue_lookup(8'h22);
        issue_lookup(8'h9c);
        finish_lookups();
        check_counters();

        // Inserts to distinct slots, lookups every cycle while they drain
        write_control(32'h0);
        for (int s = 8; s < 14; s++) begin
            rnd = lcg_next();
            key = {ref_valid[s] ? ref_tag[s] : rnd[31:28], 4'(s)};
            batch_key[s - 8] = key;
            send_update(key, rnd[23:8], 1'b1);
        end
        write_control(32'h1);
        for (int i = 0; i < 48; i++) begin
            rnd = lcg_next();
            issue_lookup((i % 4 == 3) ? rnd[31:24] : batch_key[i % 6]);
        end
        finish_lookups();
        wait_drained();
        ref_drain_all();
        check_counters();

        // Counter clear and bus errors
        write_control(32'h3);
        for (int i = 0; i < htfu_pkg::CNT_NUM; i++) begin
            ref_cnt[i] = '0;
        end
        check_counters();
        read_expect(htfu_pkg::REG_CONTROL, 32'h1);
        apb_access(1'b0, 8'h40, '0, rdata, err);
        if (!err) begin
            report_failure("read of unmapped offset 0x40 returned no pslverr");
        end
        apb_access(1'b1, htfu_pkg::REG_STATUS, 32'h5, rdata, err);
        if (!err) begin
            report_failure("write to REG_STATUS returned no pslverr");
        end
        read_expect(htfu_pkg::REG_STATUS, '0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/htfu_pkg.sv
source/htfu_regs.sv
source/htfu_stash.sv
source/htfu_drain_ctrl.sv
source/htfu_table.sv
source/htfu_lookup_result.sv
source/htfu_top.sv
sim/tb_clk_gen.sv
sim/htfu_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the run by its log
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -j 0 --top-module htfu_tb -f vlog.f \
    && ./obj_dir/Vhtfu_tb; } > sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
